// ==== hw/audio_pkg.sv ====
// sample format and Q format shared by the data path; gains and pans use q_bits fraction bits
package audio_pkg;

  ////////////////////////////////////////////////////////////////////
  // sample format
  ////////////////////////////////////////////////////////////////////

  localparam int audio_width    = 24;
  localparam int nr_of_channels = 4;

  // fixed point, unity gain is 1 << q_bits
  localparam int q_bits = 16;
  localparam int q_one  = 1 << q_bits;

  typedef logic signed [audio_width-1:0] sample_t;

  // one sample per input channel, channel 0 in the low word
  typedef sample_t [nr_of_channels-1:0] channels_t;

  ////////////////////////////////////////////////////////////////////
  // saturation limits
  ////////////////////////////////////////////////////////////////////

  localparam sample_t sample_max = {1'b0, {(audio_width-1){1'b1}}};
  localparam sample_t sample_min = {1'b1, {(audio_width-1){1'b0}}};

endpackage

// ==== hw/mix_ctrl_pkg.sv ====
// gain, pan and clip flag types; compile after audio_pkg, pan above unity acts as full right
package mix_ctrl_pkg;

  // unsigned Q8.16, q_one is unity
  typedef logic [audio_pkg::audio_width-1:0] gain_t;
  typedef gain_t [audio_pkg::nr_of_channels-1:0] gains_t;

  // right side share: 0 is hard left, q_one is hard right
  typedef logic [audio_pkg::audio_width-1:0] pan_t;
  typedef pan_t [audio_pkg::nr_of_channels-1:0] pans_t;

  ////////////////////////////////////////////////////////////////////
  // clip reporting
  ////////////////////////////////////////////////////////////////////

  typedef logic [audio_pkg::nr_of_channels-1:0] chan_clip_t; // one bit per channel

  // bit 0 left, bit 1 right
  typedef logic [1:0] out_clip_t;

  // about five seconds of led hold at 125 MHz
  localparam int clip_hold_default = 625000000;

endpackage

// ==== hw/mix_frame_if.sv ====
// one mixed stereo frame per valid pulse; out_clip holds its value until the next frame
interface mix_frame_if;

  import audio_pkg::*;
  import mix_ctrl_pkg::*;

  sample_t   left;
  sample_t   right;
  logic      valid;    // single cycle strobe
  out_clip_t out_clip; // saturation per output side

  // mixer core side
  modport producer (
    output left, right, valid, out_clip
  );

  // egress and clip indicator side
  modport consumer (
    input left, right, valid, out_clip
  );

endinterface

// ==== hw/mixer_core.sv ====
// three stage mixer; accepts a strobe every cycle with no stall, gains and pans are static levels
module mixer_core (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     x_valid,
  input  audio_pkg::channels_t     x_data,
  input  mix_ctrl_pkg::gains_t     gain,
  input  mix_ctrl_pkg::pans_t      pan,
  input  mix_ctrl_pkg::gain_t      out_gain,
  mix_frame_if.producer            frame,
  output mix_ctrl_pkg::chan_clip_t chan_clip
);

  import audio_pkg::*;
  import mix_ctrl_pkg::*;

  localparam int wide_width  = 64; // holds every product before saturation
  localparam int acc_width   = audio_width + $clog2(nr_of_channels) + 1;
  localparam int share_width = q_bits + 1;

  typedef logic signed [wide_width-1:0] wide_t;
  typedef logic signed [acc_width-1:0]  acc_t;

  // clamp to the sample range and report whether it had to
  function automatic sample_t saturate(input wide_t x, output logic clip);
    clip = 1'b1;
    if (x > wide_t'(sample_max)) return sample_max;
    if (x < wide_t'(sample_min)) return sample_min;
    clip = 1'b0;
    return sample_t'(x);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stage 1: channel gain
  //////////////////////////////////////////////////////////////////////

  sample_t [nr_of_channels-1:0] ch_gained;
  chan_clip_t                   ch_clip;
  sample_t [nr_of_channels-1:0] s1_ch;
  chan_clip_t                   s1_clip;
  logic                         s1_valid;

  always_comb begin
    for (int c = 0; c < nr_of_channels; c++) begin
      ch_gained[c] = saturate((wide_t'(x_data[c]) * wide_t'({1'b0, gain[c]})) >>> q_bits,
                              ch_clip[c]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: pan and sum per side
  //////////////////////////////////////////////////////////////////////

  acc_t       sum_left;
  acc_t       sum_right;
  acc_t       s2_left;
  acc_t       s2_right;
  chan_clip_t s2_clip;
  logic       s2_valid;

  always_comb begin : pan_sum
    logic [share_width-1:0] r_share;
    logic [share_width-1:0] l_share;
    sum_left  = '0;
    sum_right = '0;
    for (int c = 0; c < nr_of_channels; c++) begin
      // pan above unity counts as hard right
      r_share = (pan[c] > pan_t'(q_one)) ? share_width'(q_one) : pan[c][share_width-1:0];
      l_share = share_width'(q_one) - r_share;
      sum_left  += acc_t'((wide_t'(s1_ch[c]) * wide_t'({1'b0, l_share})) >>> q_bits);
      sum_right += acc_t'((wide_t'(s1_ch[c]) * wide_t'({1'b0, r_share})) >>> q_bits);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3: output gain and saturation
  //////////////////////////////////////////////////////////////////////

  sample_t   out_left;
  sample_t   out_right;
  out_clip_t out_clip_c;

  always_comb begin
    out_left  = saturate((wide_t'(s2_left) * wide_t'({1'b0, out_gain})) >>> q_bits,
                         out_clip_c[0]);
    out_right = saturate((wide_t'(s2_right) * wide_t'({1'b0, out_gain})) >>> q_bits,
                         out_clip_c[1]);
  end

  // valid and flags through the pipe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid       <= 1'b0;
      s1_clip        <= '0;
      s2_valid       <= 1'b0;
      s2_clip        <= '0;
      frame.valid    <= 1'b0;
      frame.out_clip <= '0;
      chan_clip      <= '0;
    end else begin
      s1_valid    <= x_valid;
      s1_clip     <= x_valid ? ch_clip : '0; // flag only real samples
      s2_valid    <= s1_valid;
      s2_clip     <= s1_clip;
      frame.valid <= s2_valid;
      chan_clip   <= s2_clip;
      if (s2_valid) frame.out_clip <= out_clip_c; // held until next frame
    end
  end

  // sample data
  always_ff @(posedge clk) begin
    if (x_valid) s1_ch <= ch_gained;
    if (s1_valid) begin
      s2_left  <= sum_left;
      s2_right <= sum_right;
    end
    if (s2_valid) begin
      frame.left  <= out_left;
      frame.right <= out_right;
    end
  end

endmodule

// ==== hw/dac_egress.sv ====
// sends left then right under valid/ready; frames that arrive during a transfer are dropped
module dac_egress (
  input  logic               clk,
  input  logic               rst_n,
  mix_frame_if.consumer      frame,
  output audio_pkg::sample_t dac_data,
  output logic               dac_valid,
  output logic               dac_last,
  input  logic               dac_ready
);

  import audio_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_send_left,
    st_send_right
  } state_t;

  state_t  state;
  sample_t right_hold; // right word waits here while left is out

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      dac_valid <= 1'b0;
      dac_last  <= 1'b0;
    end else begin
      case (state)
        st_idle: if (frame.valid) begin
          state     <= st_send_left;
          dac_valid <= 1'b1;
          dac_last  <= 1'b0;
        end
        st_send_left: if (dac_ready) begin
          state    <= st_send_right;
          dac_last <= 1'b1; // right word closes the frame
        end
        st_send_right: if (dac_ready) begin
          state     <= st_idle;
          dac_valid <= 1'b0;
          dac_last  <= 1'b0;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && frame.valid) begin
      dac_data   <= frame.left;
      right_hold <= frame.right;
    end else if (state == st_send_left && dac_ready) begin
      dac_data <= right_hold;
    end
  end

  // word must not change under a stalled handshake
  a_dac_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dac_valid && !dac_ready |=> dac_valid && $stable(dac_data) && $stable(dac_last));

endmodule

// ==== hw/dac_level_monitor.sv ====
// observes the DAC handshake only; clear wins over a transfer in the same cycle
module dac_level_monitor (
  input  logic               clk,
  input  logic               rst_n,
  input  audio_pkg::sample_t dac_data,
  input  logic               dac_valid,
  input  logic               dac_ready,
  input  logic               clear,
  output audio_pkg::sample_t min_level,
  output audio_pkg::sample_t max_level
);

  import audio_pkg::*;

  logic xfer;

  assign xfer = dac_valid && dac_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      min_level <= sample_max; // empty range
      max_level <= sample_min;
    end else if (clear) begin
      min_level <= sample_max;
      max_level <= sample_min;
    end else if (xfer) begin
      // signed compares, sample_t is signed
      if (dac_data < min_level) min_level <= dac_data;
      if (dac_data > max_level) max_level <= dac_data;
    end
  end

  // once a word has gone out the range is never inverted
  a_range_order: assert property (@(posedge clk) disable iff (!rst_n)
    xfer && !clear |=> min_level <= max_level);

endmodule

// ==== hw/clip_indicator.sv ====
// clip led with restartable hold; hold_cycles must be positive and fit a 31 bit int
module clip_indicator #(
  parameter int hold_cycles = mix_ctrl_pkg::clip_hold_default
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mix_ctrl_pkg::chan_clip_t chan_clip,
  mix_frame_if.consumer            frame,
  output logic                     clip_led
);

  localparam int cnt_width = $clog2(hold_cycles + 1);

  logic                 clip_event;
  logic                 active;
  logic [cnt_width-1:0] count; // cycles of hold left

  // out_clip is only meaningful with its frame
  assign clip_event = (|chan_clip) || (frame.valid && (|frame.out_clip));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      count  <= '0;
    end else if (clip_event) begin
      active <= 1'b1;
      count  <= cnt_width'(hold_cycles); // restart on every clip
    end else if (active) begin
      count <= count - 1'b1;
      if (count == cnt_width'(1)) active <= 1'b0;
    end
  end

  assign clip_led = active;

  a_led_count: assert property (@(posedge clk) disable iff (!rst_n)
    clip_led |-> count != '0);

endmodule

// ==== hw/mixer_top.sv ====
// four channel stereo mixer top; controls are static levels, frames are dropped while the DAC is busy
module mixer_top #(
  parameter int clip_hold = mix_ctrl_pkg::clip_hold_default
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     x_valid,
  input  audio_pkg::channels_t     x_data,
  input  mix_ctrl_pkg::gains_t     gain,
  input  mix_ctrl_pkg::pans_t      pan,
  input  mix_ctrl_pkg::gain_t      out_gain,
  output audio_pkg::sample_t       dac_data,
  output logic                     dac_valid,
  output logic                     dac_last,
  input  logic                     dac_ready,
  input  logic                     cmd_clear_min_max,
  output mix_ctrl_pkg::chan_clip_t sr_chan_clip,
  output mix_ctrl_pkg::out_clip_t  sr_out_clip,
  output audio_pkg::sample_t       sr_min_dac,
  output audio_pkg::sample_t       sr_max_dac,
  output logic                     clip_led
);

  import mix_ctrl_pkg::*;

  chan_clip_t  chan_clip;
  mix_frame_if frame ();

  mixer_core mixer_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .x_valid   (x_valid),
    .x_data    (x_data),
    .gain      (gain),
    .pan       (pan),
    .out_gain  (out_gain),
    .frame     (frame.producer),
    .chan_clip (chan_clip)
  );

  dac_egress dac_egress_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .frame     (frame.consumer),
    .dac_data  (dac_data),
    .dac_valid (dac_valid),
    .dac_last  (dac_last),
    .dac_ready (dac_ready)
  );

  dac_level_monitor dac_level_monitor_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .dac_data  (dac_data),
    .dac_valid (dac_valid),
    .dac_ready (dac_ready),
    .clear     (cmd_clear_min_max),
    .min_level (sr_min_dac),
    .max_level (sr_max_dac)
  );

  clip_indicator #(
    .hold_cycles (clip_hold)
  ) clip_indicator_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .chan_clip (chan_clip),
    .frame     (frame.consumer),
    .clip_led  (clip_led)
  );

  // flags of the latest frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr_chan_clip <= '0;
      sr_out_clip  <= '0;
    end else if (frame.valid) begin
      sr_chan_clip <= chan_clip;
      sr_out_clip  <= frame.out_clip;
    end
  end

endmodule

// ==== dv/mixer_tb.sv ====
// directed testbench for mixer_top; clip hold cut to 32 cycles, controls change only between frames
module mixer_tb;

  import audio_pkg::*;
  import mix_ctrl_pkg::*;

  localparam int clip_hold   = 32;
  localparam int cycle_limit = 4000; // about twice the length of all tests
  localparam int dac_latency = 4;    // x_valid to dac_valid

  logic       clk;
  logic       rst_n;
  logic       x_valid;
  channels_t  x_data;
  gains_t     gain;
  pans_t      pan;
  gain_t      out_gain;
  sample_t    dac_data;
  logic       dac_valid;
  logic       dac_last;
  logic       dac_ready;
  logic       cmd_clear_min_max;
  chan_clip_t sr_chan_clip;
  out_clip_t  sr_out_clip;
  sample_t    sr_min_dac;
  sample_t    sr_max_dac;
  logic       clip_led;

  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  logic [15:0] lfsr;
  int          frame_start; // cycle at the strobe of the last frame
  logic        led_at_dac;  // clip_led when dac_valid first rose
  sample_t     seen_min;
  sample_t     seen_max;

  mixer_top #(
    .clip_hold (clip_hold)
  ) mixer_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .x_valid           (x_valid),
    .x_data            (x_data),
    .gain              (gain),
    .pan               (pan),
    .out_gain          (out_gain),
    .dac_data          (dac_data),
    .dac_valid         (dac_valid),
    .dac_last          (dac_last),
    .dac_ready         (dac_ready),
    .cmd_clear_min_max (cmd_clear_min_max),
    .sr_chan_clip      (sr_chan_clip),
    .sr_out_clip       (sr_out_clip),
    .sr_min_dac        (sr_min_dac),
    .sr_max_dac        (sr_max_dac),
    .clip_led          (clip_led)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus source
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (out_bit) lfsr = lfsr ^ 16'hB400;
    return out_bit;
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  function automatic channels_t random_frame();
    channels_t   d;
    logic [19:0] v;
    for (int c = 0; c < nr_of_channels; c++) begin
      v    = 20'(draw_bits(20));
      d[c] = sample_t'($signed(v)); // well inside the sample range
    end
    return d;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic longint clamp(input longint v, output logic clip);
    clip = (v > sample_max) || (v < sample_min);
    if (v > sample_max) return sample_max;
    if (v < sample_min) return sample_min;
    return v;
  endfunction

  function automatic void mix_model(input channels_t d, output sample_t l, output sample_t r,
                                    output chan_clip_t cc, output out_clip_t oc);
    longint ch;
    longint share;
    longint sum_l;
    longint sum_r;
    logic   clip;
    sum_l = 0;
    sum_r = 0;
    for (int c = 0; c < nr_of_channels; c++) begin
      ch    = clamp((longint'(d[c]) * longint'(gain[c])) >>> q_bits, clip);
      cc[c] = clip;
      share = (pan[c] > q_one) ? q_one : longint'(pan[c]); // right share
      sum_l += (ch * (q_one - share)) >>> q_bits;
      sum_r += (ch * share) >>> q_bits;
    end
    l     = sample_t'(clamp((sum_l * longint'(out_gain)) >>> q_bits, clip));
    oc[0] = clip;
    r     = sample_t'(clamp((sum_r * longint'(out_gain)) >>> q_bits, clip));
    oc[1] = clip;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_chan_clip(input string name, input chan_clip_t got,
                                 input chan_clip_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_out_clip(input string name, input out_clip_t got, input out_clip_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // frame driver
  //////////////////////////////////////////////////////////////////////

  task automatic set_controls(input gains_t g, input pans_t p, input gain_t og);
    @(posedge clk);
    gain     <= g;
    pan      <= p;
    out_gain <= og;
  endtask

  // one strobe, then both dac words; stall puts random gaps into dac_ready
  task automatic run_frame(input channels_t d, input logic stall,
                           output sample_t l, output sample_t r);
    sample_t    exp_l;
    sample_t    exp_r;
    chan_clip_t exp_cc;
    out_clip_t  exp_oc;
    sample_t    held_data;
    logic       held_last;
    logic       stalled;
    int         latency;
    int         got;
    l = '0;
    r = '0;
    @(posedge clk);
    mix_model(d, exp_l, exp_r, exp_cc, exp_oc);
    x_valid   <= 1'b1;
    x_data    <= d;
    dac_ready <= stall ? lfsr_step() : 1'b1;
    @(negedge clk);
    frame_start = cycle;
    latency     = 0;
    while (!dac_valid && latency < 10) begin
      @(posedge clk);
      x_valid   <= 1'b0;
      dac_ready <= stall ? lfsr_step() : 1'b1;
      @(negedge clk);
      latency++;
    end
    if (latency != dac_latency) begin
      errors++;
      $display("dac_valid rose %0d cycles after x_valid instead of %0d", latency, dac_latency);
    end
    led_at_dac = clip_led;
    got        = 0;
    stalled    = 1'b0;
    while (got < 2) begin
      if (!dac_valid) begin
        errors++;
        $display("dac_valid dropped before the right word was sent");
        break;
      end
      if (stalled) begin
        check_sample("dac_data", dac_data, held_data);
        check_led("dac_last", dac_last, held_last);
      end
      if (dac_ready) begin
        check_led("dac_last", dac_last, got == 1); // only on the right word
        if (got == 0) l = dac_data;
        else r = dac_data;
        got++;
        stalled = 1'b0;
      end else begin
        held_data = dac_data;
        held_last = dac_last;
        stalled   = 1'b1;
      end
      @(posedge clk);
      dac_ready <= stall ? lfsr_step() : 1'b1;
      @(negedge clk);
    end
    if (got == 2) check_led("dac_valid", dac_valid, 1'b0);
    check_sample("left", l, exp_l);
    check_sample("right", r, exp_r);
    check_chan_clip("sr_chan_clip", sr_chan_clip, exp_cc);
    check_out_clip("sr_out_clip", sr_out_clip, exp_oc);
    if (l < seen_min) seen_min = l;
    if (r < seen_min) seen_min = r;
    if (l > seen_max) seen_max = l;
    if (r > seen_max) seen_max = r;
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    cmd_clear_min_max <= 1'b1;
    @(posedge clk);
    cmd_clear_min_max <= 1'b0;
    @(negedge clk);
    check_sample("sr_min_dac", sr_min_dac, sample_max);
    check_sample("sr_max_dac", sr_max_dac, sample_min);
    seen_min = sample_max;
    seen_max = sample_min;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("test %s done, %0d errors", name, errors - errors_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_led("dac_valid", dac_valid, 1'b0);
    check_led("dac_last", dac_last, 1'b0);
    check_led("clip_led", clip_led, 1'b0);
    check_sample("sr_min_dac", sr_min_dac, sample_max);
    check_sample("sr_max_dac", sr_max_dac, sample_min);
    report_test("reset_values", err0);
  endtask

  task automatic test_unity_mix();
    int      err0;
    gains_t  g;
    pans_t   p;
    sample_t l;
    sample_t r;
    err0 = errors;
    for (int c = 0; c < nr_of_channels; c++) begin
      g[c] = gain_t'(q_one);
      p[c] = pan_t'(q_one / 2); // centre
    end
    set_controls(g, p, gain_t'(q_one));
    repeat (12) run_frame(random_frame(), 1'b0, l, r);
    report_test("unity_mix", err0);
  endtask

  task automatic test_pan_extremes();
    int        err0;
    gains_t    g;
    pans_t     p;
    channels_t d;
    channels_t rnd;
    sample_t   l;
    sample_t   r;
    err0 = errors;
    g = {gain_t'(3 * q_one / 4), gain_t'(q_one), gain_t'(2 * q_one), gain_t'(q_one / 2)};
    p = {pan_t'(q_one + 100), pan_t'(q_one / 4), pan_t'(q_one), pan_t'(0)};
    set_controls(g, p, gain_t'(q_one));
    rnd = random_frame();
    d = '0;
    d[0] = rnd[0]; // hard left
    run_frame(d, 1'b0, l, r);
    check_sample("right of hard left channel", r, '0);
    d = '0;
    d[1] = rnd[1]; // hard right
    run_frame(d, 1'b0, l, r);
    check_sample("left of hard right channel", l, '0);
    d = '0;
    d[3] = rnd[3]; // beyond unity acts as hard right
    run_frame(d, 1'b0, l, r);
    check_sample("left of over range pan", l, '0);
    repeat (12) run_frame(random_frame(), 1'b0, l, r);
    report_test("pan_extremes", err0);
  endtask

  task automatic test_back_pressure();
    int      err0;
    sample_t l;
    sample_t r;
    err0 = errors;
    repeat (16) run_frame(random_frame(), 1'b1, l, r);
    @(posedge clk);
    dac_ready <= 1'b1;
    report_test("back_pressure", err0);
  endtask

  task automatic test_saturation_clip();
    int        err0;
    gains_t    g;
    pans_t     p;
    channels_t d;
    sample_t   l;
    sample_t   r;
    err0 = errors;
    @(negedge clk);
    check_led("clip_led", clip_led, 1'b0);
    for (int c = 0; c < nr_of_channels; c++) begin
      g[c] = gain_t'(q_one);
      p[c] = pan_t'(q_one / 2);
    end
    g[2] = gain_t'(255 * q_one);
    set_controls(g, p, gain_t'(4 * q_one));
    d = '0;
    d[2] = sample_t'(100000);
    run_frame(d, 1'b0, l, r);
    check_sample("left", l, sample_max);
    check_sample("right", r, sample_max);
    check_chan_clip("sr_chan_clip", sr_chan_clip, chan_clip_t'(4'b0100));
    check_out_clip("sr_out_clip", sr_out_clip, 2'b11);
    check_led("clip_led", led_at_dac, 1'b1);
    d[2] = sample_t'(-100000); // second clip restarts the hold
    run_frame(d, 1'b0, l, r);
    check_sample("left", l, sample_min);
    check_sample("right", r, sample_min);
    check_out_clip("sr_out_clip", sr_out_clip, 2'b11);
    while (clip_led && cycle < frame_start + 200) @(negedge clk);
    if (cycle != frame_start + dac_latency + clip_hold) begin
      errors++;
      $display("clip_led fell at cycle %0d instead of %0d", cycle,
               frame_start + dac_latency + clip_hold);
    end
    report_test("saturation_clip", err0);
  endtask

  task automatic test_level_monitor();
    int      err0;
    gains_t  g;
    pans_t   p;
    sample_t l;
    sample_t r;
    err0 = errors;
    for (int c = 0; c < nr_of_channels; c++) g[c] = gain_t'(q_one);
    p = {pan_t'(q_one / 4), pan_t'(q_one / 2), pan_t'(q_one), pan_t'(0)};
    set_controls(g, p, gain_t'(q_one));
    pulse_clear();
    repeat (6) run_frame(random_frame(), 1'b0, l, r);
    check_sample("sr_min_dac", sr_min_dac, seen_min);
    check_sample("sr_max_dac", sr_max_dac, seen_max);
    pulse_clear();
    report_test("level_monitor", err0);
  endtask

  initial begin
    rst_n             = 1'b0;
    x_valid           = 1'b0;
    x_data            = '0;
    gain              = '0;
    pan               = '0;
    out_gain          = '0;
    dac_ready         = 1'b1;
    cmd_clear_min_max = 1'b0;
    lfsr              = 16'd59786;
    seen_min          = sample_max;
    seen_max          = sample_min;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_unity_mix();
    test_pan_extremes();
    test_back_pressure();
    test_saturation_clip();
    test_level_monitor();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("TESTBENCH PASSED");
    else $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/audio_pkg.sv
hw/mix_ctrl_pkg.sv
hw/mix_frame_if.sv
hw/mixer_core.sv
hw/dac_egress.sv
hw/dac_level_monitor.sv
hw/clip_indicator.sv
hw/mixer_top.sv
dv/mixer_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mixer_tb
RTL_TOP    := mixer_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_TEXT  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
